//--- logic/regfile_pkg.sv
package regfile_pkg;

  ////////////////////
  // Widths and counts
  ////////////////////

  // Width of one register
  localparam int unsigned DATA_WIDTH = 32;

  // Full register address, bank bit on top of the index
  localparam int unsigned ADDR_WIDTH = 6;

  // Index of a register inside one bank
  localparam int unsigned IDX_WIDTH = 5;

  // Registers in each bank
  localparam int unsigned NUM_WORDS = 32;

  ////////////////////
  // Types
  ////////////////////

  // One register value
  typedef logic [DATA_WIDTH-1:0] data_t;

  // Address as seen at the ports, bit 5 is the bank
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // Register number within a bank
  typedef logic [IDX_WIDTH-1:0] idx_t;

  // One bit per register of a bank
  typedef logic [NUM_WORDS-1:0] word_mask_t;

  // Bank selection, taken straight from address bit 5
  typedef enum logic {
    BANK_INT = 1'b0,
    BANK_FP  = 1'b1
  } bank_e;

endpackage

//--- logic/write_decoder.sv
module write_decoder #(
  parameter int unsigned FPU = 0
) (
  input  regfile_pkg::addr_t      waddr_a_i,
  input  regfile_pkg::addr_t      waddr_b_i,
  input  logic                    we_a_i,
  input  logic                    we_b_i,
  output regfile_pkg::word_mask_t int_we_o,
  output regfile_pkg::word_mask_t fp_we_o,
  output regfile_pkg::word_mask_t int_sel_b_o,
  output regfile_pkg::word_mask_t fp_sel_b_o
);

  import regfile_pkg::*;

  // Bit of x0 inside the integer mask
  localparam word_mask_t X0_MASK = word_mask_t'(1);

  idx_t       idx_a;
  idx_t       idx_b;
  bank_e      bank_a;
  bank_e      bank_b;
  word_mask_t onehot_a;
  word_mask_t onehot_b;
  word_mask_t int_a;
  word_mask_t int_b;
  word_mask_t fp_a;
  word_mask_t fp_b;

  // Split both write addresses into bank and index
  assign idx_a  = waddr_a_i[IDX_WIDTH-1:0];
  assign idx_b  = waddr_b_i[IDX_WIDTH-1:0];
  assign bank_a = bank_e'(waddr_a_i[IDX_WIDTH]);
  assign bank_b = bank_e'(waddr_b_i[IDX_WIDTH]);

  ////////////////////
  // One-hot decode
  ////////////////////

  // Compare each index with every register number, qualified by the enable
  always_comb begin
    for (int i = 0; i < NUM_WORDS; i++) begin
      onehot_a[i] = we_a_i && (idx_a == idx_t'(i));
      onehot_b[i] = we_b_i && (idx_b == idx_t'(i));
    end
  end

  // Route each decode to the bank it addresses
  assign int_a = (bank_a == BANK_INT) ? onehot_a : '0;
  assign int_b = (bank_b == BANK_INT) ? onehot_b : '0;

  // Without an FP bank those writes go nowhere
  assign fp_a = (bank_a == BANK_FP && FPU == 1) ? onehot_a : '0;
  assign fp_b = (bank_b == BANK_FP && FPU == 1) ? onehot_b : '0;

  ////////////////////
  // Enables and port-B selects
  ////////////////////

  // Either port writing makes the register load, x0 never loads
  assign int_we_o    = (int_a | int_b) & ~X0_MASK;
  // Port B wins a collision on the same register
  assign int_sel_b_o = int_b & ~X0_MASK;

  assign fp_we_o     = fp_a | fp_b;
  assign fp_sel_b_o  = fp_b;

endmodule

//--- logic/int_bank.sv
module int_bank (
  input  logic                    clk_int,
  input  logic                    rst_n,
  input  regfile_pkg::word_mask_t we_i,
  input  regfile_pkg::word_mask_t sel_b_i,
  input  regfile_pkg::data_t      wdata_a_i,
  input  regfile_pkg::data_t      wdata_b_i,
  input  regfile_pkg::idx_t       ridx_a_i,
  input  regfile_pkg::idx_t       ridx_b_i,
  input  regfile_pkg::idx_t       ridx_c_i,
  output regfile_pkg::data_t      rdata_a_o,
  output regfile_pkg::data_t      rdata_b_o,
  output regfile_pkg::data_t      rdata_c_o
);

  import regfile_pkg::*;

  // Storage for x1..x31 only
  data_t mem_q [NUM_WORDS-1:1];
  // Read view with x0 tied to zero
  data_t rd_view [NUM_WORDS];

  ////////////////////
  // Write
  ////////////////////

  always_ff @(posedge clk_int or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < NUM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      for (int i = 1; i < NUM_WORDS; i++) begin
        // Port B data when its select is set, else port A
        if (we_i[i]) begin
          mem_q[i] <= sel_b_i[i] ? wdata_b_i : wdata_a_i;
        end
      end
    end
  end

  ////////////////////
  // Read
  ////////////////////

  always_comb begin
    rd_view[0] = '0;
    for (int i = 1; i < NUM_WORDS; i++) begin
      rd_view[i] = mem_q[i];
    end
  end

  // Combinational read, old value while a write is pending
  assign rdata_a_o = rd_view[ridx_a_i];
  assign rdata_b_o = rd_view[ridx_b_i];
  assign rdata_c_o = rd_view[ridx_c_i];

endmodule

//--- logic/fp_bank.sv
module fp_bank (
  input  logic                    clk_int,
  input  logic                    rst_n,
  input  regfile_pkg::word_mask_t we_i,
  input  regfile_pkg::word_mask_t sel_b_i,
  input  regfile_pkg::data_t      wdata_a_i,
  input  regfile_pkg::data_t      wdata_b_i,
  input  regfile_pkg::idx_t       ridx_a_i,
  input  regfile_pkg::idx_t       ridx_b_i,
  input  regfile_pkg::idx_t       ridx_c_i,
  output regfile_pkg::data_t      rdata_a_o,
  output regfile_pkg::data_t      rdata_b_o,
  output regfile_pkg::data_t      rdata_c_o
);

  import regfile_pkg::*;

  // f0..f31, every entry writable
  data_t mem_q [NUM_WORDS];

  ////////////////////
  // Write
  ////////////////////

  always_ff @(posedge clk_int or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_WORDS; i++) begin
        // Same load rule as the integer bank, port B first
        if (we_i[i]) begin
          mem_q[i] <= sel_b_i[i] ? wdata_b_i : wdata_a_i;
        end
      end
    end
  end

  ////////////////////
  // Read
  ////////////////////

  assign rdata_a_o = mem_q[ridx_a_i];
  assign rdata_b_o = mem_q[ridx_b_i];
  assign rdata_c_o = mem_q[ridx_c_i];

endmodule

//--- logic/read_mux.sv
module read_mux #(
  parameter int unsigned FPU = 0
) (
  input  regfile_pkg::bank_e bank_a_i,
  input  regfile_pkg::bank_e bank_b_i,
  input  regfile_pkg::bank_e bank_c_i,
  input  regfile_pkg::data_t int_rdata_a_i,
  input  regfile_pkg::data_t int_rdata_b_i,
  input  regfile_pkg::data_t int_rdata_c_i,
  input  regfile_pkg::data_t fp_rdata_a_i,
  input  regfile_pkg::data_t fp_rdata_b_i,
  input  regfile_pkg::data_t fp_rdata_c_i,
  output regfile_pkg::data_t rdata_a_o,
  output regfile_pkg::data_t rdata_b_o,
  output regfile_pkg::data_t rdata_c_o
);

  import regfile_pkg::*;

  // Pick the word of the addressed bank for one port
  function automatic data_t pick(bank_e bank, data_t int_word, data_t fp_word);
    data_t word;
    if (bank == BANK_INT) begin
      word = int_word;
    end else if (FPU == 1) begin
      word = fp_word;
    end else begin
      // No FP bank, so FP addresses read zero
      word = '0;
    end
    return word;
  endfunction

  ////////////////////
  // Per-port select
  ////////////////////

  assign rdata_a_o = pick(bank_a_i, int_rdata_a_i, fp_rdata_a_i);
  assign rdata_b_o = pick(bank_b_i, int_rdata_b_i, fp_rdata_b_i);
  assign rdata_c_o = pick(bank_c_i, int_rdata_c_i, fp_rdata_c_i);

endmodule

//--- logic/regfile_top.sv
module regfile_top #(
  parameter int unsigned FPU = 1
) (
  input  logic               clk_int,
  input  logic               rst_n,
  // Read ports
  input  regfile_pkg::addr_t raddr_a_i,
  input  regfile_pkg::addr_t raddr_b_i,
  input  regfile_pkg::addr_t raddr_c_i,
  output regfile_pkg::data_t rdata_a_o,
  output regfile_pkg::data_t rdata_b_o,
  output regfile_pkg::data_t rdata_c_o,
  // Write port A
  input  regfile_pkg::addr_t waddr_a_i,
  input  regfile_pkg::data_t wdata_a_i,
  input  logic               we_a_i,
  // Write port B, wins on collision
  input  regfile_pkg::addr_t waddr_b_i,
  input  regfile_pkg::data_t wdata_b_i,
  input  logic               we_b_i
);

  import regfile_pkg::*;

  // Read address split
  idx_t       ridx_a;
  idx_t       ridx_b;
  idx_t       ridx_c;
  bank_e      rbank_a;
  bank_e      rbank_b;
  bank_e      rbank_c;

  // Decoder outputs
  word_mask_t int_we;
  word_mask_t fp_we;
  word_mask_t int_sel_b;
  word_mask_t fp_sel_b;

  // Bank read data
  data_t      int_rdata_a;
  data_t      int_rdata_b;
  data_t      int_rdata_c;
  data_t      fp_rdata_a;
  data_t      fp_rdata_b;
  data_t      fp_rdata_c;

  // Index is the low bits, bank is bit 5
  assign ridx_a  = raddr_a_i[IDX_WIDTH-1:0];
  assign ridx_b  = raddr_b_i[IDX_WIDTH-1:0];
  assign ridx_c  = raddr_c_i[IDX_WIDTH-1:0];
  assign rbank_a = bank_e'(raddr_a_i[IDX_WIDTH]);
  assign rbank_b = bank_e'(raddr_b_i[IDX_WIDTH]);
  assign rbank_c = bank_e'(raddr_c_i[IDX_WIDTH]);

  ////////////////////
  // Write decode
  ////////////////////

  write_decoder #(
    .FPU (FPU)
  ) u_write_decoder (
    .waddr_a_i   (waddr_a_i),
    .waddr_b_i   (waddr_b_i),
    .we_a_i      (we_a_i),
    .we_b_i      (we_b_i),
    .int_we_o    (int_we),
    .fp_we_o     (fp_we),
    .int_sel_b_o (int_sel_b),
    .fp_sel_b_o  (fp_sel_b)
  );

  ////////////////////
  // Banks
  ////////////////////

  int_bank u_int_bank (
    .clk_int   (clk_int),
    .rst_n     (rst_n),
    .we_i      (int_we),
    .sel_b_i   (int_sel_b),
    .wdata_a_i (wdata_a_i),
    .wdata_b_i (wdata_b_i),
    .ridx_a_i  (ridx_a),
    .ridx_b_i  (ridx_b),
    .ridx_c_i  (ridx_c),
    .rdata_a_o (int_rdata_a),
    .rdata_b_o (int_rdata_b),
    .rdata_c_o (int_rdata_c)
  );

  // FP bank only exists with FPU=1
  if (FPU == 1) begin : gen_fp
    fp_bank u_fp_bank (
      .clk_int   (clk_int),
      .rst_n     (rst_n),
      .we_i      (fp_we),
      .sel_b_i   (fp_sel_b),
      .wdata_a_i (wdata_a_i),
      .wdata_b_i (wdata_b_i),
      .ridx_a_i  (ridx_a),
      .ridx_b_i  (ridx_b),
      .ridx_c_i  (ridx_c),
      .rdata_a_o (fp_rdata_a),
      .rdata_b_o (fp_rdata_b),
      .rdata_c_o (fp_rdata_c)
    );
  end else begin : gen_no_fp
    // Nothing stored, FP reads are zero
    assign fp_rdata_a = '0;
    assign fp_rdata_b = '0;
    assign fp_rdata_c = '0;
  end

  ////////////////////
  // Output select
  ////////////////////

  read_mux #(
    .FPU (FPU)
  ) u_read_mux (
    .bank_a_i      (rbank_a),
    .bank_b_i      (rbank_b),
    .bank_c_i      (rbank_c),
    .int_rdata_a_i (int_rdata_a),
    .int_rdata_b_i (int_rdata_b),
    .int_rdata_c_i (int_rdata_c),
    .fp_rdata_a_i  (fp_rdata_a),
    .fp_rdata_b_i  (fp_rdata_b),
    .fp_rdata_c_i  (fp_rdata_c),
    .rdata_a_o     (rdata_a_o),
    .rdata_b_o     (rdata_b_o),
    .rdata_c_o     (rdata_c_o)
  );

endmodule

//--- testbench/regfile_tb.sv
module regfile_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import regfile_pkg::*;

  ////////////////////
  // Run constants
  ////////////////////

  localparam int CLK_HALF    = 20;
  localparam int RST_CYCLES  = 8;
  localparam int SEED        = 32'h7faa;
  // Cycles spent by each test
  localparam int T1_CYCLES   = 64;
  localparam int T2_CYCLES   = 32;
  localparam int T3_CYCLES   = 400;
  localparam int T4_CYCLES   = 64;
  localparam int T5_CYCLES   = 64;
  localparam int T6_CYCLES   = 64;
  localparam int CYCLE_LIMIT = RST_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
                               + T4_CYCLES + T5_CYCLES + T6_CYCLES + 100;

  logic  clk_int;
  logic  rst_n;
  addr_t raddr_a;
  addr_t raddr_b;
  addr_t raddr_c;
  data_t rdata_a;
  data_t rdata_b;
  data_t rdata_c;
  addr_t waddr_a;
  addr_t waddr_b;
  data_t wdata_a;
  data_t wdata_b;
  logic  we_a;
  logic  we_b;

  // Reference contents, index is the full 6-bit address
  data_t model [64];
  int    checks;
  int    errors;
  int    test_errors;
  int    cycle_cnt;
  addr_t prev;
  addr_t tgt;

  regfile_top #(
    .FPU (1)
  ) DUT (
    .clk_int   (clk_int),
    .rst_n     (rst_n),
    .raddr_a_i (raddr_a),
    .raddr_b_i (raddr_b),
    .raddr_c_i (raddr_c),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .rdata_c_o (rdata_c),
    .waddr_a_i (waddr_a),
    .wdata_a_i (wdata_a),
    .we_a_i    (we_a),
    .waddr_b_i (waddr_b),
    .wdata_b_i (wdata_b),
    .we_b_i    (we_b)
  );

  initial begin
    clk_int = 1'b0;
    forever #(CLK_HALF) clk_int = ~clk_int;
  end

  // Watchdog, counts rising edges up to the limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk_int);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
    $display("test failed");
    $finish;
  end

  ////////////////////
  // Checks and model
  ////////////////////

  task automatic check_data(input string what, input data_t got, input data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      test_errors++;
      $display("[ERROR] %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  // One clock: drive on the falling edge, check late in the low phase
  task automatic run_cycle(input addr_t ra, input addr_t rb, input addr_t rc,
                           input addr_t wa, input data_t da, input logic wea,
                           input addr_t wb, input data_t db, input logic web);
    @(negedge clk_int);
    raddr_a = ra;
    raddr_b = rb;
    raddr_c = rc;
    waddr_a = wa;
    wdata_a = da;
    we_a    = wea;
    waddr_b = wb;
    wdata_b = db;
    we_b    = web;
    #(CLK_HALF - 1);
    check_data($sformatf("port a @%0d", ra), rdata_a, model[ra]);
    check_data($sformatf("port b @%0d", rb), rdata_b, model[rb]);
    check_data($sformatf("port c @%0d", rc), rdata_c, model[rc]);
    // Writes land at the coming edge, B applied last so it wins
    if (wea && wa != '0) model[wa] = da;
    if (web && wb != '0) model[wb] = db;
  endtask

  task automatic report_test(input string name);
    $display("Done: %-24s errors %0d", name, test_errors);
    test_errors = 0;
  endtask

  function automatic addr_t rand_addr();
    return addr_t'($urandom());
  endfunction

  function automatic data_t rand_data();
    return data_t'($urandom());
  endfunction

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    void'($urandom(SEED));
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    rst_n       = 1'b0;
    {raddr_a, raddr_b, raddr_c, waddr_a, waddr_b} = '0;
    {wdata_a, wdata_b, we_a, we_b} = '0;
    prev = '0;
    tgt  = '0;
    for (int i = 0; i < 64; i++) model[i] = '0;
    repeat (RST_CYCLES) @(posedge clk_int);
    @(negedge clk_int);
    rst_n = 1'b1;

    // All 64 addresses, spread over the three ports
    for (int i = 0; i < T1_CYCLES; i++) begin
      run_cycle(addr_t'(i), addr_t'(i + 21), addr_t'(i + 42), '0, '0, 0, '0, '0, 0);
    end
    report_test("reset values");

    // Both ports hammer x0
    for (int i = 0; i < T2_CYCLES; i++) begin
      run_cycle('0, '0, '0, '0, rand_data(), 1'($urandom()), '0, rand_data(),
                1'($urandom()));
    end
    report_test("x0 hardwired");

    for (int i = 0; i < T3_CYCLES; i++) begin
      run_cycle(rand_addr(), rand_addr(), rand_addr(), rand_addr(), rand_data(),
                1'($urandom()), rand_addr(), rand_data(), 1'($urandom()));
    end
    report_test("random traffic");

    // Same target on both ports, read it back one cycle later
    for (int i = 0; i < T4_CYCLES; i++) begin
      tgt = rand_addr();
      run_cycle(prev, tgt, rand_addr(), tgt, rand_data(), 1'b1, tgt, rand_data(), 1'b1);
      prev = tgt;
    end
    report_test("port b priority");

    // Old value in the write cycle, new value right after
    for (int i = 0; i < T5_CYCLES / 2; i++) begin
      tgt = rand_addr();
      run_cycle(tgt, tgt, tgt, tgt, rand_data(), 1'b1, rand_addr(), '0, 1'b0);
      run_cycle(tgt, tgt, rand_addr(), '0, '0, 1'b0, '0, '0, 1'b0);
    end
    report_test("read during write");

    // FP writes while reading integers, then the other way round
    for (int i = 0; i < T6_CYCLES / 2; i++) begin
      run_cycle({1'b0, idx_t'($urandom())}, {1'b0, idx_t'($urandom())},
                {1'b0, idx_t'($urandom())}, {1'b1, idx_t'($urandom())}, rand_data(),
                1'b1, {1'b1, idx_t'($urandom())}, rand_data(), 1'b1);
    end
    for (int i = 0; i < T6_CYCLES / 2; i++) begin
      run_cycle({1'b1, idx_t'($urandom())}, {1'b1, idx_t'($urandom())},
                {1'b1, idx_t'($urandom())}, {1'b0, idx_t'($urandom())}, rand_data(),
                1'b1, {1'b0, idx_t'($urandom())}, rand_data(), 1'b1);
    end
    report_test("bank isolation");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- list.f
logic/regfile_pkg.sv
logic/write_decoder.sv
logic/int_bank.sv
logic/fp_bank.sv
logic/read_mux.sv
logic/regfile_top.sv
testbench/regfile_tb.sv

//--- Makefile
# Verilator simulation of the register file testbench
# Any variable can be overridden, e.g. make test BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= regfile_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= test passed

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Output goes to the terminal and is searched for the pass line
test: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
